/* src/dsp_settings.svh */
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// Lane count and sample widths
`define CHANNEL_WIDTH     4
`define CODE_PRECISION    8

// Feed-forward equalizer and slicer
`define FFE_LENGTH        3
`define WEIGHT_PRECISION  8
`define FFE_OUT_PRECISION 18
`define SHIFT_PRECISION   4
`define THRESH_PRECISION  18

// Channel estimate and residual error
`define CHAN_DEPTH        3
`define CHAN_PRECISION    8
`define ERROR_PRECISION   10

// APB register map, one field per address
`define APB_ADDR_WIDTH    8
`define ADDR_WEIGHT_BASE  8'h00
`define ADDR_THRESH_BASE  8'h10
`define ADDR_FFE_SHIFT    8'h18
`define ADDR_CHAN_BASE    8'h20
`define ADDR_CHAN_SHIFT   8'h30

`endif

/* src/dsp_pkg.sv */
`include "dsp_settings.svh"

package dsp_pkg;

    typedef logic signed [`CODE_PRECISION-1:0]   code_t;
    typedef logic signed [`ERROR_PRECISION-1:0]  error_t;
    typedef logic signed [`WEIGHT_PRECISION-1:0] weight_t;
    typedef logic signed [`THRESH_PRECISION-1:0] thresh_t;
    typedef logic signed [`CHAN_PRECISION-1:0]   chan_tap_t;
    typedef logic        [`SHIFT_PRECISION-1:0]  shift_t;

    // Lane 0 holds the earliest sample of the word
    typedef code_t  [`CHANNEL_WIDTH-1:0] code_word_t;
    typedef logic   [`CHANNEL_WIDTH-1:0] bit_word_t;
    typedef code_t  [`CHANNEL_WIDTH-1:0] ffe_word_t;
    typedef error_t [`CHANNEL_WIDTH-1:0] error_word_t;

    typedef struct packed {
        weight_t   [`FFE_LENGTH-1:0][`CHANNEL_WIDTH-1:0] weights;
        thresh_t   [`CHANNEL_WIDTH-1:0]                  thresh;
        shift_t                                          ffe_shift;
        chan_tap_t [`CHANNEL_WIDTH-1:0][`CHAN_DEPTH-1:0] channel_est;
        shift_t                                          channel_shift;
    } dsp_cfg_t;

    // Clamp to the range of a signed field of the given width
    function automatic int sat_range(input int value, input int width);
        int hi;
        int lo;
        hi = (1 << (width - 1)) - 1;
        lo = -hi - 1;
        if (value > hi) begin
            return hi;
        end
        if (value < lo) begin
            return lo;
        end
        return value;
    endfunction

    function automatic code_t sat_code(input int value);
        return code_t'(sat_range(value, `CODE_PRECISION));
    endfunction

    function automatic error_t sat_error(input int value);
        return error_t'(sat_range(value, `ERROR_PRECISION));
    endfunction

endpackage

/* src/lane_delay.sv */
`timescale 1ns/1ps

module lane_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     reset_i,
    input  payload_t data_i,
    output payload_t data_o
);

    generate
        if (DEPTH == 0) begin : g_pass
            assign data_o = data_i;
        end else begin : g_chain
            payload_t stage_q [DEPTH];

            always_ff @(posedge clk) begin
                if (reset_i) begin
                    for (int s = 0; s < DEPTH; s++) begin
                        stage_q[s] <= '0;
                    end
                end else begin
                    stage_q[0] <= data_i;
                    for (int s = 1; s < DEPTH; s++) begin
                        stage_q[s] <= stage_q[s-1];
                    end
                end
            end

            // Oldest entry leaves the chain
            assign data_o = stage_q[DEPTH-1];
        end
    endgenerate

    // X on the input would otherwise surface here DEPTH cycles later
    a_no_unknown: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown(data_o));

endmodule

/* src/dsp_cfg_apb.sv */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_cfg_apb
    import dsp_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [31:0]                pwdata_i,
    output logic [31:0]                prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    output dsp_cfg_t                   cfg_o
);

    dsp_cfg_t    cfg_q;
    dsp_cfg_t    cfg_d;
    logic        access;
    logic        wr_en;
    logic        addr_hit;
    logic [31:0] rd_field;

    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i;

    // Address decode, read mux and write merge in one pass
    always_comb begin
        cfg_d    = cfg_q;
        rd_field = '0;
        addr_hit = 1'b0;
        // Weights are tap-major then lane
        for (int k = 0; k < `FFE_LENGTH; k++) begin
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                if (paddr_i == `ADDR_WEIGHT_BASE + k * `CHANNEL_WIDTH + i) begin
                    addr_hit = 1'b1;
                    rd_field = 32'(cfg_q.weights[k][i]);
                    if (wr_en) begin
                        cfg_d.weights[k][i] = pwdata_i[`WEIGHT_PRECISION-1:0];
                    end
                end
            end
        end
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            if (paddr_i == `ADDR_THRESH_BASE + i) begin
                addr_hit = 1'b1;
                rd_field = 32'(cfg_q.thresh[i]);
                if (wr_en) begin
                    cfg_d.thresh[i] = pwdata_i[`THRESH_PRECISION-1:0];
                end
            end
        end
        // Channel taps are lane-major then tap
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            for (int k = 0; k < `CHAN_DEPTH; k++) begin
                if (paddr_i == `ADDR_CHAN_BASE + i * `CHAN_DEPTH + k) begin
                    addr_hit = 1'b1;
                    rd_field = 32'(cfg_q.channel_est[i][k]);
                    if (wr_en) begin
                        cfg_d.channel_est[i][k] = pwdata_i[`CHAN_PRECISION-1:0];
                    end
                end
            end
        end
        // Shift amounts are unsigned
        if (paddr_i == `ADDR_FFE_SHIFT) begin
            addr_hit = 1'b1;
            rd_field = 32'(cfg_q.ffe_shift);
            if (wr_en) begin
                cfg_d.ffe_shift = pwdata_i[`SHIFT_PRECISION-1:0];
            end
        end
        if (paddr_i == `ADDR_CHAN_SHIFT) begin
            addr_hit = 1'b1;
            rd_field = 32'(cfg_q.channel_shift);
            if (wr_en) begin
                cfg_d.channel_shift = pwdata_i[`SHIFT_PRECISION-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q <= '0;
        end else begin
            cfg_q <= cfg_d;
        end
    end

    // No wait states
    assign pready_o  = access;
    assign pslverr_o = access && !addr_hit;
    assign prdata_o  = (access && !pwrite_i) ? rd_field : 32'd0;
    assign cfg_o     = cfg_q;

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (reset_i)
        penable_i |-> psel_i);

    a_psel_held: assert property (@(posedge clk) disable iff (reset_i)
        (psel_i && !penable_i) |=> psel_i);

endmodule

/* src/ffe_slicer.sv */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module ffe_slicer
    import dsp_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  dsp_cfg_t   cfg_i,
    input  code_word_t codes_i,
    output ffe_word_t  ffe_o,
    output bit_word_t  bits_o
);

    code_word_t                           prev_codes;
    code_t [2*`CHANNEL_WIDTH-1:0]         code_hist;
    logic signed [`FFE_OUT_PRECISION-1:0] ffe_sum     [`CHANNEL_WIDTH];
    logic signed [`FFE_OUT_PRECISION-1:0] ffe_shifted [`CHANNEL_WIDTH];
    ffe_word_t                            ffe_d;
    ffe_word_t                            ffe_q;
    bit_word_t                            bits_d;
    bit_word_t                            bits_q;

    // One word of code history
    lane_delay #(
        .payload_t (code_word_t),
        .DEPTH     (1)
    ) u_code_hist (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (codes_i),
        .data_o  (prev_codes)
    );

    // Previous word sits in the low half
    assign code_hist = {codes_i, prev_codes};

    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            ffe_sum[i] = '0;
            // Tap k looks k samples back, possibly into the previous word
            for (int k = 0; k < `FFE_LENGTH; k++) begin
                ffe_sum[i] = ffe_sum[i]
                           + cfg_i.weights[k][i] * code_hist[`CHANNEL_WIDTH + i - k];
            end
            ffe_shifted[i] = ffe_sum[i] >>> cfg_i.ffe_shift;
            bits_d[i]      = (ffe_shifted[i] >= cfg_i.thresh[i]);
            ffe_d[i]       = sat_code(ffe_shifted[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ffe_q  <= '0;
            bits_q <= '0;
        end else begin
            ffe_q  <= ffe_d;
            bits_q <= bits_d;
        end
    end

    assign ffe_o  = ffe_q;
    assign bits_o = bits_q;

endmodule

/* src/channel_error.sv */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module channel_error
    import dsp_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  dsp_cfg_t    cfg_i,
    input  bit_word_t   bits_i,
    input  code_word_t  codes_i,
    output code_word_t  est_codes_o,
    output error_word_t errors_o
);

    bit_word_t                    prev_bits;
    logic [2*`CHANNEL_WIDTH-1:0]  bit_hist;
    int                           est_sum [`CHANNEL_WIDTH];
    code_word_t                   est_d;
    code_word_t                   est_q;
    error_word_t                  err_d;
    error_word_t                  err_q;

    // Bits of the previous word feed the early lanes
    lane_delay #(
        .payload_t (bit_word_t),
        .DEPTH     (1)
    ) u_bit_hist (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (bits_i),
        .data_o  (prev_bits)
    );

    assign bit_hist = {bits_i, prev_bits};

    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            est_sum[i] = 0;
            // Decided bit maps to +1 or -1 times the tap
            for (int k = 0; k < `CHAN_DEPTH; k++) begin
                if (bit_hist[`CHANNEL_WIDTH + i - k]) begin
                    est_sum[i] = est_sum[i] + cfg_i.channel_est[i][k];
                end else begin
                    est_sum[i] = est_sum[i] - cfg_i.channel_est[i][k];
                end
            end
            est_d[i] = sat_code(est_sum[i] >>> cfg_i.channel_shift);
            // Residual against the ADC code of the same sample
            err_d[i] = sat_error(int'(est_d[i]) - int'(codes_i[i]));
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            est_q <= '0;
            err_q <= '0;
        end else begin
            est_q <= est_d;
            err_q <= err_d;
        end
    end

    assign est_codes_o = est_q;
    assign errors_o    = err_q;

endmodule

/* src/datapath_core.sv */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module datapath_core
    import dsp_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [31:0]                pwdata_i,
    output logic [31:0]                prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    input  code_word_t                 adc_codes_i,
    output ffe_word_t                  trunc_ffe_o,
    output bit_word_t                  sliced_bits_o,
    output code_word_t                 est_codes_o,
    output error_word_t                est_errors_o
);

    dsp_cfg_t   cfg;
    code_word_t aligned_codes;

    dsp_cfg_apb u_cfg (
        .clk       (clk),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .cfg_o     (cfg)
    );

    ffe_slicer u_ffe (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg_i   (cfg),
        .codes_i (adc_codes_i),
        .ffe_o   (trunc_ffe_o),
        .bits_o  (sliced_bits_o)
    );

    // Codes wait one cycle to meet their decided bits
    lane_delay #(
        .payload_t (code_word_t),
        .DEPTH     (1)
    ) u_code_align (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (adc_codes_i),
        .data_o  (aligned_codes)
    );

    channel_error u_chan (
        .clk         (clk),
        .reset_i     (reset_i),
        .cfg_i       (cfg),
        .bits_i      (sliced_bits_o),
        .codes_i     (aligned_codes),
        .est_codes_o (est_codes_o),
        .errors_o    (est_errors_o)
    );

endmodule

/* bench/datapath_core_tb.sv */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module datapath_core_tb
    import dsp_pkg::*;
();

    // One parsed line of the vector file
    typedef struct packed {
        logic [7:0]        kind;
        logic [16:0][31:0] val;
    } vec_t;

    logic                       clk;
    logic                       reset_i;
    logic                       psel_i;
    logic                       penable_i;
    logic                       pwrite_i;
    logic [`APB_ADDR_WIDTH-1:0] paddr_i;
    logic [31:0]                pwdata_i;
    logic [31:0]                prdata_o;
    logic                       pready_o;
    logic                       pslverr_o;
    code_word_t                 adc_codes_i;
    ffe_word_t                  trunc_ffe_o;
    bit_word_t                  sliced_bits_o;
    code_word_t                 est_codes_o;
    error_word_t                est_errors_o;

    int          seed = 32'h4019_1a6e;
    int          cycle;
    int          limit;
    vec_t        vecs [$];
    ffe_word_t   exp_ffe [$];
    bit_word_t   exp_bits [$];
    code_word_t  exp_est [$];
    error_word_t exp_err [$];
    int          ffe_due [$];
    int          est_due [$];

    datapath_core UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .adc_codes_i   (adc_codes_i),
        .trunc_ffe_o   (trunc_ffe_o),
        .sliced_bits_o (sliced_bits_o),
        .est_codes_o   (est_codes_o),
        .est_errors_o  (est_errors_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %0h expected %0h",
                               $time, name, got, exp));
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic step_cycle();
        tick();
        cycle++;
        if (ffe_due.size() > 0 && ffe_due[0] == cycle) begin
            check_value("trunc_ffe_o", trunc_ffe_o, exp_ffe.pop_front());
            check_value("sliced_bits_o", sliced_bits_o, exp_bits.pop_front());
            void'(ffe_due.pop_front());
        end
        if (est_due.size() > 0 && est_due[0] == cycle) begin
            check_value("est_codes_o", est_codes_o, exp_est.pop_front());
            check_value("est_errors_o", est_errors_o, exp_err.pop_front());
            void'(est_due.pop_front());
        end
    endtask

    task automatic drain();
        while (ffe_due.size() > 0 || est_due.size() > 0) begin
            step_cycle();
        end
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        tick();
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b1;
        paddr_i   = addr[`APB_ADDR_WIDTH-1:0];
        pwdata_i  = data;
        tick();
        penable_i = 1'b1;
        #1;
        check_value("pready_o", pready_o, 1);
        tick();
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, input logic [31:0] exp_data,
                            input logic [31:0] exp_err);
        tick();
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = addr[`APB_ADDR_WIDTH-1:0];
        tick();
        penable_i = 1'b1;
        #1;
        check_value("pready_o", pready_o, 1);
        check_value("prdata_o", prdata_o, exp_data);
        check_value("pslverr_o", pslverr_o, exp_err[0]);
        tick();
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic run_data(input vec_t v);
        code_word_t  codes;
        ffe_word_t   ffe;
        code_word_t  est;
        error_word_t err;
        step_cycle();
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            codes[i] = v.val[i][7:0];
            ffe[i]   = v.val[4+i][7:0];
            est[i]   = v.val[9+i][7:0];
            err[i]   = v.val[13+i][9:0];
        end
        adc_codes_i = codes;
        exp_ffe.push_back(ffe);
        exp_bits.push_back(v.val[8][3:0]);
        ffe_due.push_back(cycle + 1);
        exp_est.push_back(est);
        exp_err.push_back(err);
        est_due.push_back(cycle + 2);
    endtask

    task automatic load_vectors();
        int                 fd;
        int                 n;
        int                 count;
        logic [63:0]        tag;
        logic [8*128-1:0]   line_buf;
        vec_t               v;
        fd = $fopen("bench/datapath_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open bench/datapath_vectors.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1) begin
                break;
            end
            v = '0;
            v.kind = tag[7:0];
            if (tag == "#") begin
                n = $fgets(line_buf, fd);
                count = 0;
            end else if (tag == "W") begin
                count = 2;
            end else if (tag == "R") begin
                count = 3;
            end else if (tag == "D") begin
                count = 17;
            end else begin
                fail_run("Vector file holds a line with an unknown tag");
            end
            for (int j = 0; j < count; j++) begin
                n = $fscanf(fd, "%h", v.val[j]);
                if (n != 1) begin
                    fail_run("Vector file holds a malformed line");
                end
            end
            if (count > 0) begin
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    function automatic bit is_mapped(input int a);
        return (a >= `ADDR_WEIGHT_BASE && a < `ADDR_WEIGHT_BASE + `FFE_LENGTH * `CHANNEL_WIDTH)
            || (a >= `ADDR_THRESH_BASE && a < `ADDR_THRESH_BASE + `CHANNEL_WIDTH)
            || (a == `ADDR_FFE_SHIFT)
            || (a >= `ADDR_CHAN_BASE && a < `ADDR_CHAN_BASE + `CHANNEL_WIDTH * `CHAN_DEPTH)
            || (a == `ADDR_CHAN_SHIFT);
    endfunction

    initial begin
        reset_i     = 1'b1;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        adc_codes_i = '0;
        cycle       = 0;
        load_vectors();
        // Up to 4 cycles per line or register read, plus reset and margin
        limit = (vecs.size() + 64) * 4 + 10 + 100;
        fork
            begin
                repeat (limit) @(posedge clk);
                fail_run("Timeout: the run did not finish within its cycle budget");
            end
        join_none
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
        #1;
        check_value("trunc_ffe_o", trunc_ffe_o, 0);
        check_value("sliced_bits_o", sliced_bits_o, 0);
        check_value("est_codes_o", est_codes_o, 0);
        check_value("est_errors_o", est_errors_o, 0);
        check_value("pslverr_o", pslverr_o, 0);
        check_value("pready_o", pready_o, 0);
        for (int a = 0; a < 64; a++) begin
            if (is_mapped(a)) begin
                apb_read(a, 0, 0);
            end
        end
        foreach (vecs[idx]) begin
            if (vecs[idx].kind == "W") begin
                drain();
                apb_write(vecs[idx].val[0], vecs[idx].val[1]);
            end else if (vecs[idx].kind == "R") begin
                drain();
                apb_read(vecs[idx].val[0], vecs[idx].val[1], vecs[idx].val[2]);
            end else begin
                run_data(vecs[idx]);
            end
        end
        drain();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* bench/datapath_vectors.txt */
# W addr data | R addr expected_data expected_pslverr
# D code[0..3] ffe[0..3] bits est[0..3] err[0..3], lane 0 first, all hex
# Unit main tap, thresholds 0 5 -3 0
W 00 01
W 01 01
W 02 01
W 03 01
W 11 05
W 12 3fffd
R 00 00000001 0
R 12 fffffffd 0
W 14 55
R 14 00000000 1
D 0a 04 fc ff 0a 04 fc ff 1 00 00 00 00 3f6 3fc 004 001
D 80 05 fd 7f 80 05 fd 7f e 00 00 00 00 080 3fb 003 381
# Taps 2 -1 0 with shift 1, channel taps 40 -10 0
W 00 02
W 01 02
W 02 02
W 03 02
W 04 ff
W 05 ff
W 06 ff
W 07 ff
W 18 1
W 20 28
W 21 f6
W 23 28
W 24 f6
W 26 28
W 27 f6
W 29 28
W 2a f6
R 05 ffffffff 0
R 2a fffffff6 0
R 18 00000001 0
D 7f 80 00 64 3f 80 40 64 d 1e ce 32 1e 39f 04e 032 3ba
D 9c 3c 3c ce 80 6e 1e b0 6 ce 32 1e ce 032 3f6 3e2 000
# Thresholds to zero, lane 0 main channel tap 100, channel shift 1
W 11 0
W 12 0
W 20 64
W 30 1
R 20 00000064 0
D 00 00 fe 03 19 00 fe 04 b 37 0f e7 19 037 00f 3e9 016
D ff ff ff ff fd ff ff ff 0 c9 f1 f1 f1 3ca 3f2 3f2 3f2

/* files.f */
+incdir+src
src/dsp_pkg.sv
src/lane_delay.sv
src/dsp_cfg_apb.sv
src/ffe_slicer.sv
src/channel_error.sv
src/datapath_core.sv
bench/datapath_core_tb.sv
